// ==== cache_pkg.sv ====
package cache_pkg;

	// Byte address split: tag | index | offset
	localparam int addr_w = 16;
	localparam int data_w = 16;
	localparam int tag_w = 5;
	localparam int index_w = 8;
	localparam int offset_w = 3;
	localparam int index_lo = offset_w;
	localparam int tag_lo = offset_w + index_w;

	// Four 16-bit words per line, at even byte offsets
	localparam int line_words = 4;
	localparam int word_sel_w = $clog2(line_words);

	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic valid;
		logic dirty;
	} tag_entry_t;

	typedef enum logic [3:0] {
		idle = 4'b0000,
		hit = 4'b0001,
		cmp_rd_0 = 4'b0010,
		cmp_wt_0 = 4'b0011,
		wb_0 = 4'b0100,
		wb_1 = 4'b0101,
		wb_2 = 4'b0110,
		wb_3 = 4'b0111,
		fill_0 = 4'b1000,
		fill_1 = 4'b1001,
		fill_2 = 4'b1010,
		fill_3 = 4'b1011,
		fill_4 = 4'b1100,
		fill_5 = 4'b1101,
		cmp_wt_1 = 4'b1110,
		cmp_rd_1 = 4'b1111
	} ctl_state_t;

endpackage

// ==== mem_pkg.sv ====
package mem_pkg;

	// Banks interleaved on the word-in-line bits
	localparam int num_banks = 4;
	localparam int bank_sel_w = $clog2(num_banks);

	// Byte address bit 0 is never used, bank select starts at bit 1
	localparam int bank_sel_lo = 1;

	// Read data returns this many cycles after the read strobe
	localparam int mem_read_lat = 2;

endpackage

// ==== store_array.sv ====
`timescale 1ns/10ps

module store_array #(
	parameter type entry_t = logic [15:0],
	parameter int depth = 256
)(
	input logic clk,
	input logic we,
	input logic [$clog2(depth)-1:0] waddr,
	input logic [$clog2(depth)-1:0] raddr,
	input entry_t wdata,
	output entry_t rdata
);

	entry_t mem [depth];

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[waddr] <= wdata;
		end
	end

	// Asynchronous read
	assign rdata = mem[raddr];

	a_waddr_known: assert property (@(posedge clk) we |-> !$isunknown(waddr))
		else $error("store_array write to unknown address");

endmodule

// ==== cache_store.sv ====
`timescale 1ns/10ps

module cache_store
	import cache_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic cmp,
	input logic write,
	input logic valid_in,
	input logic [index_w-1:0] index,
	input logic [offset_w-1:0] offset,
	input logic [tag_w-1:0] tag_in,
	input logic [data_w-1:0] data_in,
	output logic hit,
	output logic dirty,
	output logic valid,
	output logic [tag_w-1:0] tag_out,
	output logic [data_w-1:0] data_out
);

	localparam int num_lines = 2 ** index_w;
	localparam int num_words = num_lines * line_words;

	logic [num_lines-1:0] valid_q;
	tag_entry_t entry_rd;
	tag_entry_t entry_wr;
	logic tag_match;
	logic line_we;
	logic [index_w+word_sel_w-1:0] data_addr;

	// Word within the line is offset[2:1]
	assign data_addr = {index, offset[offset_w-1 -: word_sel_w]};

	assign valid = valid_q[index] && entry_rd.valid;
	assign tag_match = entry_rd.tag == tag_in;
	assign hit = enable && valid && tag_match;
	assign dirty = valid && entry_rd.dirty;
	assign tag_out = entry_rd.tag;

	// Compare writes land only on a hit, access writes always land
	assign line_we = enable && write && (!cmp || hit);

	always_comb
	begin
		entry_wr.tag = tag_in;
		entry_wr.valid = cmp ? 1'b1 : valid_in;
		// Set by a compare write, cleared by a refill
		entry_wr.dirty = cmp;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
		end
		else if (line_we && !cmp)
		begin
			valid_q[index] <= valid_in;
		end
	end

	store_array #(
		.entry_t(tag_entry_t),
		.depth(num_lines)
	) i_tag_array (
		.clk(clk),
		.we(line_we),
		.waddr(index),
		.raddr(index),
		.wdata(entry_wr),
		.rdata(entry_rd)
	);

	store_array #(
		.entry_t(logic [data_w-1:0]),
		.depth(num_words)
	) i_data_array (
		.clk(clk),
		.we(line_we),
		.waddr(data_addr),
		.raddr(data_addr),
		.wdata(data_in),
		.rdata(data_out)
	);

	a_write_enabled: assert property (@(posedge clk) disable iff (!rst_n) write |-> enable)
		else $error("cache_store write strobe without enable");

endmodule

// ==== cache_controller.sv ====
`timescale 1ns/10ps

module cache_controller
	import cache_pkg::*;
	import mem_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic [addr_w-1:0] addr,
	input logic [data_w-1:0] data_in,
	input logic rd,
	input logic wr,
	input logic hit,
	input logic dirty,
	input logic valid,
	input logic [tag_w-1:0] tag_out,
	input logic [data_w-1:0] data_out_cache,
	input logic [data_w-1:0] mem_rdata,
	output logic enable,
	output logic cmp,
	output logic write,
	output logic valid_in,
	output logic [index_w-1:0] index,
	output logic [offset_w-1:0] offset,
	output logic [tag_w-1:0] tag_in,
	output logic [data_w-1:0] cache_wdata,
	output logic [addr_w-1:0] mem_addr,
	output logic [data_w-1:0] mem_wdata,
	output logic mem_rd,
	output logic mem_wr,
	output logic done,
	output logic cache_hit,
	output logic stall,
	output logic err
);

	ctl_state_t state;
	ctl_state_t next_state;
	logic [3:0] fill_step;
	logic [3:0] fill_back;
	logic err_fsm;

	// Refill reads go out on steps 0..3, words come back mem_read_lat later
	assign fill_step = state - fill_0;
	assign fill_back = fill_step - 4'(mem_read_lat);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= idle;
		end
		else
		begin
			state <= next_state;
		end
	end

	always_comb
	begin
		enable = 1'b0;
		cmp = 1'b0;
		write = 1'b0;
		valid_in = 1'b0;
		index = addr[index_lo +: index_w];
		offset = addr[offset_w-1:0];
		tag_in = addr[tag_lo +: tag_w];
		cache_wdata = data_in;
		mem_addr = '0;
		mem_wdata = data_out_cache;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		done = 1'b0;
		cache_hit = 1'b0;
		stall = 1'b1;
		err_fsm = 1'b0;
		next_state = state;

		case (state)
			idle:
			begin
				stall = 1'b0;
				// Read wins when both are requested
				if (rd)
					next_state = cmp_rd_0;
				else if (wr)
					next_state = cmp_wt_0;
			end
			cmp_rd_0, cmp_wt_0:
			begin
				enable = 1'b1;
				cmp = 1'b1;
				write = state == cmp_wt_0;
				if (hit)
					next_state = cache_pkg::hit;
				else if (valid && dirty)
					next_state = wb_0;
				else
					next_state = fill_0;
			end
			// Port named hit shadows the state name here
			cache_pkg::hit:
			begin
				enable = 1'b1;
				cmp = 1'b1;
				done = 1'b1;
				cache_hit = 1'b1;
				next_state = idle;
			end
			wb_0, wb_1, wb_2, wb_3:
			begin
				// Victim word goes back under its own tag
				enable = 1'b1;
				offset = {state[1:0], 1'b0};
				mem_addr = {tag_out, addr[index_lo +: index_w], state[1:0], 1'b0};
				mem_wr = 1'b1;
				if (state == wb_3)
					next_state = fill_0;
				else
					next_state = ctl_state_t'(state + 4'd1);
			end
			fill_0, fill_1, fill_2, fill_3, fill_4, fill_5:
			begin
				enable = 1'b1;
				if (fill_step < 4'(line_words))
				begin
					mem_rd = 1'b1;
					mem_addr = {addr[addr_w-1:offset_w], fill_step[1:0], 1'b0};
				end
				if (fill_step >= 4'(mem_read_lat))
				begin
					write = 1'b1;
					valid_in = 1'b1;
					offset = {fill_back[1:0], 1'b0};
					cache_wdata = mem_rdata;
				end
				if (state != fill_5)
					next_state = ctl_state_t'(state + 4'd1);
				else if (rd)
					next_state = cmp_rd_1;
				else if (wr)
					next_state = cmp_wt_1;
				else
					next_state = idle;
			end
			cmp_rd_1, cmp_wt_1:
			begin
				enable = 1'b1;
				cmp = 1'b1;
				write = state == cmp_wt_1;
				done = 1'b1;
				next_state = idle;
			end
			default:
			begin
				err_fsm = 1'b1;
				next_state = idle;
			end
		endcase
	end

	assign err = err_fsm || (rd && wr);

	// Refill step count above is built for this latency
	initial
	begin
		assert (mem_read_lat == 2)
			else $fatal(1, "cache_controller needs a memory read latency of 2");
	end

	// No write may land while a read is still in flight
	a_mem_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rd |-> !mem_wr ##1 !mem_wr ##1 !mem_wr)
		else $error("memory write overlaps a pending read");

	a_done_state: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (state == cache_pkg::hit && $past(state) inside {cmp_rd_0, cmp_wt_0})
			|| (state inside {cmp_rd_1, cmp_wt_1} && $past(state) == fill_5))
		else $error("done outside a completing state");

endmodule

// ==== four_bank_mem.sv ====
`timescale 1ns/10ps

module four_bank_mem
	import mem_pkg::*;
#(
	parameter int bank_depth = 8192
)(
	input logic clk,
	input logic rst_n,
	input logic [15:0] addr,
	input logic [15:0] wdata,
	input logic rd,
	input logic wr,
	output logic [15:0] rdata
);

	localparam int word_w = $clog2(bank_depth);
	localparam int word_lo = bank_sel_lo + bank_sel_w;

	logic [bank_sel_w-1:0] sel;
	logic [bank_sel_w-1:0] sel_q;
	logic [word_w-1:0] word;
	logic [word_w-1:0] word_q;
	logic [15:0] bank_rdata [num_banks];
	logic [15:0] data_q;
	logic rd_v1_q;
	logic rd_v2_q;

	assign sel = addr[bank_sel_lo +: bank_sel_w];
	// Upper bits wrap when the banks are shallow
	assign word = addr[word_lo +: word_w];

	for (genvar b = 0; b < num_banks; b++)
	begin : g_bank
		store_array #(
			.entry_t(logic [15:0]),
			.depth(bank_depth)
		) i_bank (
			.clk(clk),
			.we(wr && sel == bank_sel_w'(b)),
			.waddr(word),
			.raddr(word_q),
			.wdata(wdata),
			.rdata(bank_rdata[b])
		);
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_v1_q <= 1'b0;
			rd_v2_q <= 1'b0;
		end
		else
		begin
			rd_v1_q <= rd;
			rd_v2_q <= rd_v1_q;
		end
	end

	// Stage 1 holds the request, stage 2 the selected bank word
	always_ff @(posedge clk)
	begin
		if (rd)
		begin
			sel_q <= sel;
			word_q <= word;
		end
		if (rd_v1_q)
		begin
			data_q <= bank_rdata[sel_q];
		end
	end

	assign rdata = rd_v2_q ? data_q : '0;

	a_rd_wr: assert property (@(posedge clk) disable iff (!rst_n) !(rd && wr))
		else $error("four_bank_mem read and write together");

endmodule

// ==== cache_top.sv ====
`timescale 1ns/10ps

module cache_top
	import cache_pkg::*;
	import mem_pkg::*;
#(
	parameter int bank_depth = 2 ** (addr_w - bank_sel_lo - bank_sel_w)
)(
	input logic clk,
	input logic rst_n,
	input logic [addr_w-1:0] addr,
	input logic [data_w-1:0] data_in,
	input logic rd,
	input logic wr,
	output logic [data_w-1:0] data_out,
	output logic done,
	output logic cache_hit,
	output logic stall,
	output logic err
);

	logic enable;
	logic cmp;
	logic write;
	logic valid_in;
	logic hit;
	logic dirty;
	logic valid;
	logic [index_w-1:0] index;
	logic [offset_w-1:0] offset;
	logic [tag_w-1:0] tag_in;
	logic [tag_w-1:0] tag_out;
	logic [data_w-1:0] cache_wdata;
	logic [addr_w-1:0] mem_addr;
	logic [data_w-1:0] mem_wdata;
	logic [data_w-1:0] mem_rdata;
	logic mem_rd;
	logic mem_wr;

	cache_controller i_cache_controller (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.hit(hit),
		.dirty(dirty),
		.valid(valid),
		.tag_out(tag_out),
		.data_out_cache(data_out),
		.mem_rdata(mem_rdata),
		.enable(enable),
		.cmp(cmp),
		.write(write),
		.valid_in(valid_in),
		.index(index),
		.offset(offset),
		.tag_in(tag_in),
		.cache_wdata(cache_wdata),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rd(mem_rd),
		.mem_wr(mem_wr),
		.done(done),
		.cache_hit(cache_hit),
		.stall(stall),
		.err(err)
	);

	cache_store i_cache_store (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.cmp(cmp),
		.write(write),
		.valid_in(valid_in),
		.index(index),
		.offset(offset),
		.tag_in(tag_in),
		.data_in(cache_wdata),
		.hit(hit),
		.dirty(dirty),
		.valid(valid),
		.tag_out(tag_out),
		.data_out(data_out)
	);

	four_bank_mem #(
		.bank_depth(bank_depth)
	) i_four_bank_mem (
		.clk(clk),
		.rst_n(rst_n),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rd(mem_rd),
		.wr(mem_wr),
		.rdata(mem_rdata)
	);

endmodule

// ==== tb_cache_top.sv ====
`timescale 1ns/10ps

module tb_cache_top
	import cache_pkg::*;
();

	localparam int clk_period = 20;
	localparam int reset_cycles = 4;
	localparam int random_ops = 200;
	// Accesses issued by the directed tests, in the order they run
	localparam int planned_accesses = 2 + 9 + 3 + 6 + random_ops;
	// Longest access is 12 cycles plus its start and release edges
	localparam int cycles_per_access = 16;
	localparam int watchdog_cycles = reset_cycles + 4 + planned_accesses * cycles_per_access;

	logic clk;
	logic rst_n;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] data_in;
	logic rd;
	logic wr;
	logic [data_w-1:0] data_out;
	logic done;
	logic cache_hit;
	logic stall;
	logic err;

	// Reference model, a flat word map plus the line state per index
	logic [data_w-1:0] word_model [2**(addr_w-1)];
	bit word_written [2**(addr_w-1)];
	logic [tag_w-1:0] tag_model [2**index_w];
	bit valid_model [2**index_w];
	bit dirty_model [2**index_w];

	logic [31:0] lfsr_q;
	string test_name;
	int error_count;
	int test_count;
	int failed_tests;
	int errors_at_start;

	cache_top i_cache_top (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.cache_hit(cache_hit),
		.stall(stall),
		.err(err)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			bits = {bits[30:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] tag,
		input logic [index_w-1:0] idx, input logic [1:0] word);
		return {tag, idx, word, 1'b0};
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
		error_count++;
	endtask

	task automatic report_failure(input string what);
		$display("** Error %s: %s", test_name, what);
		error_count++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
		test_count++;
	endtask

	task automatic finish_test();
		if (error_count == errors_at_start)
			$display("%s: passed", test_name);
		else
		begin
			failed_tests++;
			$display("%s: failed with %0d errors", test_name, error_count - errors_at_start);
		end
	endtask

	// Holds the request until done, sampling at the falling edge
	task automatic do_access(input logic is_write, input logic [addr_w-1:0] a,
		input logic [data_w-1:0] d, output logic [data_w-1:0] rdata,
		output logic hit_seen, output logic err_seen, output logic stall_bad,
		output logic idle_bad, output int cycles);
		logic done_seen;

		cycles = 0;
		done_seen = 1'b0;
		err_seen = 1'b0;
		stall_bad = 1'b0;
		idle_bad = 1'b0;
		rdata = '0;
		hit_seen = 1'b0;
		@(posedge clk);
		addr <= a;
		data_in <= d;
		rd <= !is_write;
		wr <= is_write;
		while (!done_seen)
		begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			if (err)
				err_seen = 1'b1;
			// Busy in every state but idle
			if (stall !== 1'b1)
				stall_bad = 1'b1;
			if (done)
			begin
				done_seen = 1'b1;
				rdata = data_out;
				hit_seen = cache_hit;
			end
		end
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		// Back in idle, done was a single pulse
		@(negedge clk);
		if (done !== 1'b0 || stall !== 1'b0)
			idle_bad = 1'b1;
	endtask

	task automatic checked_access(input logic is_write, input logic [addr_w-1:0] a,
		input logic [data_w-1:0] d);
		logic [index_w-1:0] idx;
		logic [tag_w-1:0] tag;
		logic [addr_w-2:0] w;
		logic exp_hit;
		int exp_cycles;
		logic [data_w-1:0] rdata;
		logic hit_seen;
		logic err_seen;
		logic stall_bad;
		logic idle_bad;
		int cycles;

		idx = a[index_lo +: index_w];
		tag = a[tag_lo +: tag_w];
		w = a[addr_w-1:1];
		exp_hit = valid_model[idx] && tag_model[idx] == tag;
		// Hit, clean miss with refill, dirty miss with write-back first
		if (exp_hit)
			exp_cycles = 2;
		else if (valid_model[idx] && dirty_model[idx])
			exp_cycles = 12;
		else
			exp_cycles = 8;

		do_access(is_write, a, d, rdata, hit_seen, err_seen, stall_bad, idle_bad, cycles);

		if (hit_seen !== exp_hit)
			report_mismatch($sformatf("cache_hit at %h", a), 32'(exp_hit), 32'(hit_seen));
		if (cycles != exp_cycles)
			report_mismatch($sformatf("latency at %h", a), 32'(exp_cycles), 32'(cycles));
		if (err_seen)
			report_failure($sformatf("err went high during the access to %h", a));
		if (stall_bad)
			report_failure($sformatf("stall was low while the access to %h was busy", a));
		if (idle_bad)
			report_failure($sformatf("done or stall still high after the access to %h", a));
		if (!is_write && !word_written[w])
			report_failure($sformatf("read of %h, which was never written", a));
		else if (!is_write && rdata !== word_model[w])
			report_mismatch($sformatf("data at %h", a), 32'(word_model[w]), 32'(rdata));

		if (is_write)
		begin
			word_model[w] = d;
			word_written[w] = 1'b1;
			dirty_model[idx] = 1'b1;
		end
		else if (!exp_hit)
		begin
			dirty_model[idx] = 1'b0;
		end
		valid_model[idx] = 1'b1;
		tag_model[idx] = tag;
	endtask

	task automatic test_reset();
		start_test("reset");
		@(negedge clk);
		if (stall !== 1'b0)
			report_mismatch("stall", 32'd0, 32'(stall));
		if (done !== 1'b0)
			report_mismatch("done", 32'd0, 32'(done));
		if (cache_hit !== 1'b0)
			report_mismatch("cache_hit", 32'd0, 32'(cache_hit));
		if (err !== 1'b0)
			report_mismatch("err", 32'd0, 32'(err));
		finish_test();
	endtask

	task automatic test_write_read();
		logic [31:0] r;
		logic [addr_w-1:0] a;

		start_test("write_read");
		take_bits(15, r);
		a = make_addr(r[14:10], r[9:2], r[1:0]);
		take_bits(16, r);
		// Cold miss first, then a hit
		checked_access(1'b1, a, r[15:0]);
		checked_access(1'b0, a, '0);
		finish_test();
	endtask

	task automatic test_line_fill();
		logic [31:0] r;
		logic [tag_w-1:0] tag_a;
		logic [tag_w-1:0] tag_b;
		logic [index_w-1:0] idx;
		logic [1:0] first;

		start_test("line_fill");
		take_bits(20, r);
		tag_a = r[4:0];
		tag_b = r[9:5];
		if (tag_b == tag_a)
			tag_b = tag_a + 5'd1;
		idx = r[17:10];
		first = r[19:18];
		for (int k = 0; k < line_words; k++)
		begin
			take_bits(16, r);
			checked_access(1'b1, make_addr(tag_a, idx, 2'(k)), r[15:0]);
		end
		// Evicting pushes the whole dirty line to memory
		take_bits(16, r);
		checked_access(1'b1, make_addr(tag_b, idx, first), r[15:0]);
		// One miss brings the line back, the other words hit
		for (int k = 0; k < line_words; k++)
			checked_access(1'b0, make_addr(tag_a, idx, first + 2'(k)), '0);
		finish_test();
	endtask

	task automatic test_eviction();
		logic [31:0] r;
		logic [tag_w-1:0] tag_a;
		logic [tag_w-1:0] tag_b;
		logic [addr_w-1:0] addr_a;

		start_test("eviction");
		take_bits(22, r);
		tag_a = r[4:0];
		tag_b = r[9:5];
		if (tag_b == tag_a)
			tag_b = tag_a + 5'd1;
		addr_a = make_addr(tag_a, r[17:10], r[19:18]);
		take_bits(16, r);
		checked_access(1'b1, addr_a, r[15:0]);
		take_bits(16, r);
		checked_access(1'b1, make_addr(tag_b, addr_a[index_lo +: index_w], r[1:0]), r[15:0]);
		checked_access(1'b0, addr_a, '0);
		finish_test();
	endtask

	task automatic test_latency();
		logic [31:0] r;
		logic [addr_w-1:0] addr_a;
		logic [addr_w-1:0] addr_b;

		start_test("latency");
		take_bits(15, r);
		addr_a = make_addr(r[14:10], r[9:2], r[1:0]);
		addr_b = addr_a ^ (16'b1 << tag_lo);
		take_bits(16, r);
		checked_access(1'b1, addr_a, r[15:0]);
		checked_access(1'b0, addr_a, '0);
		take_bits(16, r);
		checked_access(1'b1, addr_b, r[15:0]);
		// Dirty miss, then a clean miss, then a hit
		checked_access(1'b0, addr_a, '0);
		checked_access(1'b0, addr_b, '0);
		checked_access(1'b0, addr_b, '0);
		finish_test();
	endtask

	task automatic test_random_mix();
		logic [31:0] r;
		logic [addr_w-1:0] a;
		logic is_write;

		start_test("random_mix");
		for (int n = 0; n < random_ops; n++)
		begin
			take_bits(8, r);
			// Four tags over eight indices keeps conflicts frequent
			a = make_addr({r[1:0], 3'b011}, {5'b10100, r[4:2]}, r[6:5]);
			is_write = r[7] || !word_written[a[addr_w-1:1]];
			take_bits(16, r);
			checked_access(is_write, a, r[15:0]);
		end
		finish_test();
	endtask

	initial
	begin
		rst_n = 1'b0;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		lfsr_q = 32'he297cb56;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;

		test_reset();
		test_write_read();
		test_line_fill();
		test_eviction();
		test_latency();
		test_random_mix();

		@(posedge clk);
		$display("Tests run %0d, tests failed %0d, errors %0d",
			test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the DUT stopped answering",
			watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== flist.f ====
cache_pkg.sv
mem_pkg.sv
store_array.sv
cache_store.sv
cache_controller.sv
four_bank_mem.sv
cache_top.sv
tb_cache_top.sv

// ==== Makefile ====
TOP = tb_cache_top
LOG = sim.log

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean
